//--- common/conv_load_cfg.svh
`ifndef CONV_LOAD_CFG_SVH
`define CONV_LOAD_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// input row geometry
////////////////////////////////////////////////////////////////////////////

// pixels carried by one ddr row word
`define PIXELS_IN_ROW 32
`define PIXELS_IN_ROW_LOG2 5

// row buffers in the input buffer, one tile row each
`define ROW_BUFFERS 3

// output channels covered by one chunk, per mode
`define ROW_NUM_MODE0 64
`define ROW_NUM_MODE1 128

// input channels packed in one ddr word, as a power of two
`define IFS_IN_ROW_LOG2 1

// input buffer depth in words, as a power of two
`define INPUT_BUFFER_LOG2 12

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// indices and addresses
`define IDX_W 16
// per-tile sizes from the layer setup
`define SIZE_W 8

`endif

//--- common/conv_load_pkg.sv
`include "conv_load_cfg.svh"

package conv_load_pkg;

  // layer setup, sampled once while reset is high
  typedef struct packed {
    logic              mode;
    logic [`IDX_W-1:0] of;
    logic [`IDX_W-1:0] ox;
    logic [`IDX_W-1:0] oy;
    logic [`IDX_W-1:0] nif;
    logic [3:0]        nif_log2;
    logic [3:0]        ix_log2;
    logic [`IDX_W-1:0] ddr_base;
    // word columns and row groups of the whole input map
    logic [`IDX_W-1:0] ix_index_num;
    logic [`IDX_W-1:0] iy_index_num;
  } layer_cfg_t;

  // position of a tile start along x or y
  typedef enum logic [1:0] {
    phase_first,
    phase_mid,
    phase_last
  } tile_phase_e;

  // precomputed tile sizes, indexed by phase
  // split is indexed by y phase, then x phase
  typedef struct packed {
    logic [2:0][`SIZE_W-1:0]      col_words;
    logic [2:0][`SIZE_W-1:0]      row_num;
    logic [2:0][2:0][`SIZE_W-1:0] split;
  } tile_sizes_t;

  // geometry of the tile being loaded
  typedef struct packed {
    tile_phase_e         x_phase;
    tile_phase_e         y_phase;
    logic [`SIZE_W-1:0]  col_words;
    logic [`SIZE_W-1:0]  rows;
    logic [`SIZE_W-1:0]  split;
    logic [2*`SIZE_W-1:0] tile_words;
  } tile_geom_t;

  typedef enum logic [1:0] {
    load_idle,
    load_active,
    // tile words all loaded, waiting for the last channel chunk
    load_tile_held
  } load_phase_e;

  // indices of the word being read
  typedef struct packed {
    logic [`IDX_W-1:0] if_start;
    logic [`IDX_W-1:0] col_idx;
    logic [`IDX_W-1:0] row_idx;
    logic [1:0]        buf_num;
    logic [`IDX_W-1:0] row_group;
  } load_pos_t;

  // load-info fifo entry
  typedef struct packed {
    logic [31-2-`IDX_W:0] pad;
    logic [1:0]           buf_num;
    logic [`IDX_W-1:0]    buf_adr;
  } fifo_word_t;

endpackage

//--- list.f
+incdir+common
common/conv_load_pkg.sv
tile_walk/tile_walker.sv
tile_walk/tile_size_select.sv
logic/load_sequencer.sv
logic/row_index_counter.sv
logic/load_address_gen.sv
logic/conv_input_loader.sv
verification/conv_input_loader_sva.sv
verification/conv_input_loader_tb.sv

//--- logic/conv_input_loader.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module conv_input_loader (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  conv_load_pkg::tile_sizes_t sizes,
  input  logic                       conv_load_input,
  input  logic                       ddr_en,
  output logic                       ddr_rd_en,
  output logic [`IDX_W-1:0]          ddr_rd_adr,
  output logic                       fifo_wr_en,
  output conv_load_pkg::fifo_word_t  fifo_wr_data,
  output conv_load_pkg::load_pos_t   pos,
  output logic                       load_fin
);

  conv_load_pkg::layer_cfg_t   cfg_q;
  conv_load_pkg::tile_sizes_t  sizes_q;
  conv_load_pkg::tile_phase_e  x_phase;
  conv_load_pkg::tile_phase_e  y_phase;
  conv_load_pkg::tile_geom_t   geom;

  logic              f_last;
  logic              rd_strobe;
  logic              pair_wrap;
  logic              tile_done;
  logic              tile_empty;
  logic [`IDX_W-1:0] if_start;
  logic [`IDX_W-1:0] col_idx;
  logic [`IDX_W-1:0] row_idx;
  logic [1:0]        buf_num;
  logic [`IDX_W-1:0] row_group;

  // layer setup is captured while reset is held
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_q   <= cfg;
      sizes_q <= sizes;
    end
  end

  tile_walker u_tile_walker (
    .clk             (clk),
    .reset           (reset),
    .cfg             (cfg_q),
    .conv_load_input (conv_load_input),
    .tile_done       (tile_done),
    .tile_empty      (tile_empty),
    .load_fin        (load_fin),
    .x_phase         (x_phase),
    .y_phase         (y_phase),
    .f_last          (f_last)
  );

  tile_size_select u_tile_size_select (
    .x_phase (x_phase),
    .y_phase (y_phase),
    .sizes   (sizes_q),
    .geom    (geom)
  );

  load_sequencer u_load_sequencer (
    .clk             (clk),
    .reset           (reset),
    .cfg             (cfg_q),
    .geom            (geom),
    .conv_load_input (conv_load_input),
    .ddr_en          (ddr_en),
    .f_last          (f_last),
    .rd_strobe       (rd_strobe),
    .pair_wrap       (pair_wrap),
    .if_start        (if_start),
    .tile_done       (tile_done),
    .tile_empty      (tile_empty),
    .load_fin        (load_fin)
  );

  row_index_counter u_row_index_counter (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg_q),
    .pair_wrap (pair_wrap),
    .col_idx   (col_idx),
    .row_idx   (row_idx),
    .buf_num   (buf_num),
    .row_group (row_group)
  );

  load_address_gen u_load_address_gen (
    .cfg        (cfg_q),
    .if_start   (if_start),
    .col_idx    (col_idx),
    .row_idx    (row_idx),
    .buf_num    (buf_num),
    .row_group  (row_group),
    .ddr_rd_adr (ddr_rd_adr),
    .fifo_word  (fifo_wr_data)
  );

  // every ddr read pushes its load info
  assign ddr_rd_en  = rd_strobe;
  assign fifo_wr_en = rd_strobe;

  always_comb begin
    pos.if_start  = if_start;
    pos.col_idx   = col_idx;
    pos.row_idx   = row_idx;
    pos.buf_num   = buf_num;
    pos.row_group = row_group;
  end

endmodule

//--- logic/load_address_gen.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module load_address_gen (
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  logic [`IDX_W-1:0]          if_start,
  input  logic [`IDX_W-1:0]          col_idx,
  input  logic [`IDX_W-1:0]          row_idx,
  input  logic [1:0]                 buf_num,
  input  logic [`IDX_W-1:0]          row_group,
  output logic [`IDX_W-1:0]          ddr_rd_adr,
  output conv_load_pkg::fifo_word_t  fifo_word
);

  logic [4:0]        ch_shift;
  logic [4:0]        row_shift;
  logic [4:0]        mask_bits;
  logic [`IDX_W-1:0] buf_mask;
  logic [31:0]       col_wide;
  logic [`IDX_W-1:0] col_term;
  logic [`IDX_W-1:0] ch_term;
  logic [`IDX_W-1:0] row_term;
  logic [`IDX_W-1:0] grp_term;

  // words per pixel column and words per input row, as shifts
  assign ch_shift  = 5'(cfg.nif_log2 - `IFS_IN_ROW_LOG2);
  assign row_shift = 5'(cfg.nif_log2 + cfg.ix_log2 - `IFS_IN_ROW_LOG2 - `PIXELS_IN_ROW_LOG2);

  // first pixel of the column word, scaled to words
  assign col_wide = (32'(col_idx - `IDX_W'd1) << `PIXELS_IN_ROW_LOG2) << ch_shift;
  assign col_term = `IDX_W'(col_wide >> `PIXELS_IN_ROW_LOG2);

  // channel pair inside the pixel column
  assign ch_term  = `IDX_W'((if_start - `IDX_W'd1) >> `IFS_IN_ROW_LOG2);

  assign row_term = (row_idx - `IDX_W'd1) << row_shift;

  ////////////////////////////////////////////////////////////////////////////
  // ddr and buffer addresses
  ////////////////////////////////////////////////////////////////////////////

  assign ddr_rd_adr = cfg.ddr_base + row_term + col_term + ch_term;

  // buffer keeps only as many row groups as fit its depth
  assign mask_bits = 5'(`INPUT_BUFFER_LOG2) - row_shift;
  assign buf_mask  = {`IDX_W{1'b1}} >> (5'(`IDX_W) - mask_bits);
  assign grp_term  = (row_group & buf_mask) << row_shift;

  always_comb begin
    fifo_word.pad     = '0;
    fifo_word.buf_num = buf_num;
    fifo_word.buf_adr = grp_term + col_term + ch_term;
  end

endmodule

//--- logic/load_sequencer.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module load_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_load_pkg::layer_cfg_t cfg,
  input  conv_load_pkg::tile_geom_t geom,
  input  logic                      conv_load_input,
  input  logic                      ddr_en,
  input  logic                      f_last,
  output logic                      rd_strobe,
  output logic                      pair_wrap,
  output logic [`IDX_W-1:0]         if_start,
  output logic                      tile_done,
  output logic                      tile_empty,
  output logic                      load_fin
);

  conv_load_pkg::load_phase_e phase;
  conv_load_pkg::load_phase_e phase_nxt;

  logic [`IDX_W:0]      if_next;
  logic [`SIZE_W-1:0]   chunk_cnt;
  logic [2*`SIZE_W-1:0] tile_cnt;
  logic                 held;
  logic                 tile_wrap;
  logic                 chunk_end;

  assign held       = (phase == conv_load_pkg::load_tile_held);
  assign tile_empty = (geom.tile_words == '0);

  ////////////////////////////////////////////////////////////////////////////
  // word issue
  ////////////////////////////////////////////////////////////////////////////

  // one read per cycle while loading and ddr accepts
  assign rd_strobe = (phase == conv_load_pkg::load_active) && ddr_en;

  // each word carries two channels
  assign if_next   = if_start + `IDX_W'(1 << `IFS_IN_ROW_LOG2);
  assign pair_wrap = rd_strobe && (if_next > cfg.nif);

  // word position counts close on the last channel pair
  assign tile_wrap = pair_wrap && (tile_cnt == geom.tile_words);
  assign chunk_end = pair_wrap && ((chunk_cnt == geom.split) || (tile_cnt == geom.tile_words));

  // empty or held tile finishes the chunk at once
  assign load_fin  = chunk_end || (conv_load_input && (tile_empty || held));
  assign tile_done = tile_wrap || held;

  always_ff @(posedge clk) begin
    if (reset) begin
      if_start <= `IDX_W'd1;
    end else if (rd_strobe) begin
      if_start <= pair_wrap ? `IDX_W'd1 : if_next[`IDX_W-1:0];
    end
  end

  // chunk counter restarts every chunk, tile counter every tile
  always_ff @(posedge clk) begin
    if (reset) begin
      chunk_cnt <= `SIZE_W'd1;
      tile_cnt  <= (2*`SIZE_W)'(1);
    end else if (pair_wrap) begin
      chunk_cnt <= chunk_end ? `SIZE_W'd1 : chunk_cnt + `SIZE_W'd1;
      tile_cnt  <= tile_wrap ? (2*`SIZE_W)'(1) : tile_cnt + (2*`SIZE_W)'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // load phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    phase_nxt = phase;
    case (phase)
      conv_load_pkg::load_idle: begin
        if (conv_load_input && !tile_empty) begin
          phase_nxt = conv_load_pkg::load_active;
        end
      end
      conv_load_pkg::load_active: begin
        // tile finished early, later chunks find it already loaded
        if (chunk_end) begin
          phase_nxt = (tile_wrap && !f_last) ? conv_load_pkg::load_tile_held
                                             : conv_load_pkg::load_idle;
        end
      end
      conv_load_pkg::load_tile_held: begin
        if (f_last) begin
          phase_nxt = conv_load_pkg::load_idle;
        end
      end
      default: begin
        phase_nxt = conv_load_pkg::load_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= conv_load_pkg::load_idle;
    end else begin
      phase <= phase_nxt;
    end
  end

endmodule

//--- logic/row_index_counter.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module row_index_counter (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_load_pkg::layer_cfg_t cfg,
  input  logic                      pair_wrap,
  output logic [`IDX_W-1:0]         col_idx,
  output logic [`IDX_W-1:0]         row_idx,
  output logic [1:0]                buf_num,
  output logic [`IDX_W-1:0]         row_group
);

  logic col_wrap;
  logic row_wrap;
  logic buf_wrap;

  // column words run 1..ix_index_num, then the row steps
  assign col_wrap = pair_wrap && (col_idx == cfg.ix_index_num);
  assign row_wrap = col_wrap && (row_idx == cfg.iy_index_num);
  // rows rotate through the three row buffers
  assign buf_wrap = (buf_num == 2'(`ROW_BUFFERS));

  always_ff @(posedge clk) begin
    if (reset) begin
      col_idx <= `IDX_W'd1;
    end else if (pair_wrap) begin
      col_idx <= col_wrap ? `IDX_W'd1 : col_idx + `IDX_W'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      row_idx   <= `IDX_W'd1;
      buf_num   <= 2'd1;
      row_group <= '0;
    end else if (row_wrap) begin
      // whole map loaded, back to the first row
      row_idx   <= `IDX_W'd1;
      buf_num   <= 2'd1;
      row_group <= '0;
    end else if (col_wrap) begin
      row_idx   <= row_idx + `IDX_W'd1;
      buf_num   <= buf_wrap ? 2'd1 : buf_num + 2'd1;
      // one row group per full turn of the buffers
      row_group <= buf_wrap ? row_group + `IDX_W'd1 : row_group;
    end
  end

endmodule

//--- tile_walk/tile_size_select.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module tile_size_select (
  input  conv_load_pkg::tile_phase_e x_phase,
  input  conv_load_pkg::tile_phase_e y_phase,
  input  conv_load_pkg::tile_sizes_t sizes,
  output conv_load_pkg::tile_geom_t  geom
);

  logic [`SIZE_W-1:0]   col_words;
  logic [`SIZE_W-1:0]   rows;
  logic [2*`SIZE_W-1:0] tile_words;

  // word columns follow the x phase, rows follow the y phase
  assign col_words = sizes.col_words[x_phase];
  assign rows      = sizes.row_num[y_phase];

  // words per channel pair over the whole tile
  // a zero here marks an empty tile
  assign tile_words = col_words * rows;

  always_comb begin
    geom.x_phase    = x_phase;
    geom.y_phase    = y_phase;
    geom.col_words  = col_words;
    geom.rows       = rows;
    // word positions loaded per chunk, table is y phase major
    geom.split      = sizes.split[y_phase][x_phase];
    geom.tile_words = tile_words;
  end

endmodule

//--- tile_walk/tile_walker.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module tile_walker (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  logic                       conv_load_input,
  input  logic                       tile_done,
  input  logic                       tile_empty,
  input  logic                       load_fin,
  output conv_load_pkg::tile_phase_e x_phase,
  output conv_load_pkg::tile_phase_e y_phase,
  output logic                       f_last
);

  logic              start_q;
  logic [`IDX_W-1:0] row_num;
  logic [`IDX_W-1:0] f_start;
  logic [`IDX_W:0]   f_next;
  logic              f_wrap;
  logic              f_last_q;
  logic [`IDX_W-1:0] x_start;
  logic [`IDX_W-1:0] y_start;
  logic [`IDX_W:0]   x_next;
  logic [`IDX_W:0]   y_next;
  logic              x_adv;
  logic              x_wrap;
  logic              y_wrap;

  // first start, last start when the next step passes the limit
  function automatic conv_load_pkg::tile_phase_e classify(
    input logic [`IDX_W-1:0] start,
    input logic [`IDX_W:0]   next,
    input logic [`IDX_W-1:0] limit
  );
    if (start == `IDX_W'd1) begin
      return conv_load_pkg::phase_first;
    end else if (next > limit) begin
      return conv_load_pkg::phase_last;
    end
    return conv_load_pkg::phase_mid;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // output channel chunks
  ////////////////////////////////////////////////////////////////////////////

  assign row_num = cfg.mode ? `IDX_W'(`ROW_NUM_MODE1) : `IDX_W'(`ROW_NUM_MODE0);
  assign f_next  = f_start + row_num;
  // the registered start steps past of on the last chunk
  assign f_wrap  = start_q && (f_next > cfg.of);
  assign f_last  = f_wrap | f_last_q;

  // start pulse delayed one cycle, chunk advances after it
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= conv_load_input;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      f_start <= `IDX_W'd1;
    end else if (start_q) begin
      f_start <= f_wrap ? `IDX_W'd1 : f_next[`IDX_W-1:0];
    end
  end

  // last chunk still loading, keep the flag until its fin
  always_ff @(posedge clk) begin
    if (reset) begin
      f_last_q <= 1'b0;
    end else if (load_fin) begin
      f_last_q <= 1'b0;
    end else if (f_wrap && !x_adv) begin
      f_last_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tile x and y starts
  ////////////////////////////////////////////////////////////////////////////

  // tile done, held or empty, and no more channel chunks
  assign x_adv  = f_last && (tile_done || tile_empty);
  assign x_next = x_start + `IDX_W'(`PIXELS_IN_ROW);
  assign x_wrap = x_adv && (x_next > cfg.ox);
  assign y_next = y_start + `IDX_W'(`ROW_BUFFERS);
  assign y_wrap = x_wrap && (y_next > cfg.oy);

  always_ff @(posedge clk) begin
    if (reset) begin
      x_start <= `IDX_W'd1;
    end else if (x_adv) begin
      x_start <= x_wrap ? `IDX_W'd1 : x_next[`IDX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      y_start <= `IDX_W'd1;
    end else if (x_wrap) begin
      y_start <= y_wrap ? `IDX_W'd1 : y_next[`IDX_W-1:0];
    end
  end

  assign x_phase = classify(x_start, x_next, cfg.ox);
  assign y_phase = classify(y_start, y_next, cfg.oy);

endmodule

//--- verification/conv_input_loader_sva.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module conv_input_loader_sva (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  logic                       conv_load_input,
  input  logic                       ddr_en,
  input  logic                       ddr_rd_en,
  input  logic [`IDX_W-1:0]          ddr_rd_adr,
  input  logic                       fifo_wr_en,
  input  conv_load_pkg::fifo_word_t  fifo_wr_data,
  input  conv_load_pkg::load_pos_t   pos,
  input  logic                       load_fin
);

  // count of failed assertions
  int fail_cnt = 0;

  logic              started;
  logic              pending;
  logic [`IDX_W-1:0] exp_if;

  // column and channel part of an address, shared by ddr and buffer
  function automatic int unsigned word_in_row(
    input conv_load_pkg::load_pos_t  p,
    input conv_load_pkg::layer_cfg_t c
  );
    int unsigned col_term;
    int unsigned ch_term;
    col_term = ((p.col_idx - 1) * 32 * (1 << (int'(c.nif_log2) - 1))) / 32;
    ch_term  = (p.if_start - 1) / 2;
    return col_term + ch_term;
  endfunction

  function automatic logic [`IDX_W-1:0] ddr_adr_model(
    input conv_load_pkg::load_pos_t  p,
    input conv_load_pkg::layer_cfg_t c
  );
    int unsigned row_words;
    row_words = 1 << (int'(c.nif_log2) - 1 + int'(c.ix_log2) - 5);
    return `IDX_W'(c.ddr_base + (p.row_idx - 1) * row_words + word_in_row(p, c));
  endfunction

  // buffer keeps 2**(12 - row shift) row groups, then wraps
  function automatic logic [31:0] fifo_model(
    input conv_load_pkg::load_pos_t  p,
    input conv_load_pkg::layer_cfg_t c
  );
    int          row_shift;
    int unsigned groups;
    int unsigned adr;
    row_shift = int'(c.nif_log2) - 1 + int'(c.ix_log2) - 5;
    groups    = 1 << (`INPUT_BUFFER_LOG2 - row_shift);
    adr       = (p.row_group % groups) * (1 << row_shift) + word_in_row(p, c);
    return 32'({p.buf_num, `IDX_W'(adr)});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference state
  ////////////////////////////////////////////////////////////////////////////

  // started after the first start, pending from start to fin
  // exp_if is the channel start the next read must carry
  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      pending <= 1'b0;
      exp_if  <= `IDX_W'd1;
    end else begin
      if (conv_load_input) begin
        started <= 1'b1;
      end
      if (load_fin) begin
        pending <= 1'b0;
      end else if (conv_load_input) begin
        pending <= 1'b1;
      end
      // channel pairs step by two and wrap past nif
      if (ddr_rd_en) begin
        exp_if <= (exp_if + 2 > cfg.nif) ? `IDX_W'd1 : exp_if + `IDX_W'd2;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // strobes and chunk protocol
  ////////////////////////////////////////////////////////////////////////////

  a_rd_needs_en: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> ddr_en)
    else begin
      $error("%0t: read issued while ddr_en was low", $time);
      fail_cnt++;
    end

  a_fifo_with_rd: assert property (@(posedge clk) disable iff (reset)
    fifo_wr_en == ddr_rd_en)
    else begin
      $error("%0t: fifo write and ddr read strobes differ", $time);
      fail_cnt++;
    end

  a_quiet_before_start: assert property (@(posedge clk) disable iff (reset)
    !started && !conv_load_input |-> !ddr_rd_en && !fifo_wr_en && !load_fin)
    else begin
      $error("%0t: strobe seen before the first start", $time);
      fail_cnt++;
    end

  a_rd_inside_chunk: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> pending)
    else begin
      $error("%0t: read issued outside a chunk", $time);
      fail_cnt++;
    end

  a_fin_once: assert property (@(posedge clk) disable iff (reset)
    load_fin |-> pending || conv_load_input)
    else begin
      $error("%0t: load_fin without an open chunk", $time);
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // indices and addresses
  ////////////////////////////////////////////////////////////////////////////

  a_if_order: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> pos.if_start == exp_if)
    else begin
      $error("ERROR %0t: channel start %0d, expected %0d", $time,
        $sampled(pos.if_start), $sampled(exp_if));
      fail_cnt++;
    end

  // column steps only after the last channel pair
  a_col_step: assert property (@(posedge clk) disable iff (reset)
    $changed(pos.col_idx) |-> $past(ddr_rd_en) && ($past(pos.if_start) + 2 > cfg.nif))
    else begin
      $error("ERROR %0t: column index moved mid pair loop", $time);
      fail_cnt++;
    end

  a_buf_rotation: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> pos.buf_num == 2'((pos.row_idx - 1) % 3 + 1)
              && pos.row_group == (pos.row_idx - 1) / 3)
    else begin
      $error("ERROR %0t: buffer %0d group %0d for row %0d", $time,
        $sampled(pos.buf_num), $sampled(pos.row_group), $sampled(pos.row_idx));
      fail_cnt++;
    end

  a_ddr_adr: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> ddr_rd_adr == ddr_adr_model(pos, cfg))
    else begin
      $error("ERROR %0t: ddr address %0h, expected %0h", $time,
        $sampled(ddr_rd_adr), ddr_adr_model($sampled(pos), cfg));
      fail_cnt++;
    end

  a_fifo_data: assert property (@(posedge clk) disable iff (reset)
    fifo_wr_en |-> fifo_wr_data == fifo_model(pos, cfg))
    else begin
      $error("ERROR %0t: fifo word %0h, expected %0h", $time,
        $sampled(fifo_wr_data), fifo_model($sampled(pos), cfg));
      fail_cnt++;
    end

endmodule

bind conv_input_loader conv_input_loader_sva u_sva (
  .clk             (clk),
  .reset           (reset),
  .cfg             (cfg),
  .conv_load_input (conv_load_input),
  .ddr_en          (ddr_en),
  .ddr_rd_en       (ddr_rd_en),
  .ddr_rd_adr      (ddr_rd_adr),
  .fifo_wr_en      (fifo_wr_en),
  .fifo_wr_data    (fifo_wr_data),
  .pos             (pos),
  .load_fin        (load_fin)
);

//--- verification/conv_input_loader_tb.sv
`timescale 1ns/1ps
`include "conv_load_cfg.svh"

module conv_input_loader_tb;

  localparam int CLK_PERIOD = 20;

  logic                       clk;
  logic                       reset;
  logic                       conv_load_input;
  logic                       ddr_en;
  conv_load_pkg::layer_cfg_t  cfg;
  conv_load_pkg::tile_sizes_t sizes;
  logic                       ddr_rd_en;
  logic [`IDX_W-1:0]          ddr_rd_adr;
  logic                       fifo_wr_en;
  conv_load_pkg::fifo_word_t  fifo_wr_data;
  conv_load_pkg::load_pos_t   pos;
  logic                       load_fin;

  logic [31:0] lfsr_state;
  int          tb_errors;
  int          tests_run;
  int          idle_errs;

  conv_input_loader dut (
    .clk             (clk),
    .reset           (reset),
    .cfg             (cfg),
    .sizes           (sizes),
    .conv_load_input (conv_load_input),
    .ddr_en          (ddr_en),
    .ddr_rd_en       (ddr_rd_en),
    .ddr_rd_adr      (ddr_rd_adr),
    .fifo_wr_en      (fifo_wr_en),
    .fifo_wr_data    (fifo_wr_data),
    .pos             (pos),
    .load_fin        (load_fin)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // layer setup and reference tile walk
  ////////////////////////////////////////////////////////////////////////////

  // 64 x 6 outputs, 128 output channels, 4 input channels
  function automatic conv_load_pkg::layer_cfg_t make_cfg();
    conv_load_pkg::layer_cfg_t c;
    c              = '0;
    c.mode         = 1'b0;
    c.of           = 128;
    c.ox           = 64;
    c.oy           = 6;
    c.nif          = 4;
    c.nif_log2     = 2;
    c.ix_log2      = 7;
    c.ddr_base     = 16'h0100;
    c.ix_index_num = 3;
    c.iy_index_num = 8;
    return c;
  endfunction

  // split equals the tile words, so one chunk loads a whole tile
  function automatic conv_load_pkg::tile_sizes_t make_sizes(input int last_rows);
    conv_load_pkg::tile_sizes_t s;
    s.col_words[0] = 2;
    s.col_words[1] = 3;
    s.col_words[2] = 2;
    s.row_num[0]   = 5;
    s.row_num[1]   = 5;
    s.row_num[2]   = `SIZE_W'(last_rows);
    for (int y = 0; y < 3; y++) begin
      for (int x = 0; x < 3; x++) begin
        s.split[y][x] = s.col_words[x] * s.row_num[y];
      end
    end
    return s;
  endfunction

  function automatic int tiles_x(input conv_load_pkg::layer_cfg_t c);
    return (c.ox + `PIXELS_IN_ROW - 1) / `PIXELS_IN_ROW;
  endfunction

  function automatic int tiles_y(input conv_load_pkg::layer_cfg_t c);
    return (c.oy + `ROW_BUFFERS - 1) / `ROW_BUFFERS;
  endfunction

  function automatic int chunks_per_tile(input conv_load_pkg::layer_cfg_t c);
    int rows_per_chunk;
    rows_per_chunk = c.mode ? `ROW_NUM_MODE1 : `ROW_NUM_MODE0;
    return (c.of + rows_per_chunk - 1) / rows_per_chunk;
  endfunction

  // 0 first, 2 last, 1 in between
  function automatic int phase_of_tile(input int idx, input int count);
    if (idx == 0) return 0;
    if (idx == count - 1) return 2;
    return 1;
  endfunction

  // only the first channel chunk of a tile reads, later ones find it loaded
  function automatic int chunk_reads(
    input conv_load_pkg::tile_sizes_t s,
    input conv_load_pkg::layer_cfg_t  c,
    input int tx, input int ty, input int fc
  );
    int xp;
    int yp;
    xp = phase_of_tile(tx, tiles_x(c));
    yp = phase_of_tile(ty, tiles_y(c));
    if (fc != 0) return 0;
    return (c.nif / 2) * s.col_words[xp] * s.row_num[yp];
  endfunction

  function automatic int layer_reads(
    input conv_load_pkg::tile_sizes_t s,
    input conv_load_pkg::layer_cfg_t  c
  );
    int sum;
    sum = 0;
    for (int ty = 0; ty < tiles_y(c); ty++) begin
      for (int tx = 0; tx < tiles_x(c); tx++) begin
        sum += chunk_reads(s, c, tx, ty, 0);
      end
    end
    return sum;
  endfunction

  function automatic int total_errors();
    return tb_errors + dut.u_sva.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic draw_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  // ddr accepts about three cycles in four
  always @(posedge clk) begin : ddr_en_drive
    logic b0;
    logic b1;
    #2;
    b0 = draw_bit();
    b1 = draw_bit();
    ddr_en = b0 | b1;
  end

  task automatic apply_reset(input conv_load_pkg::tile_sizes_t s);
    reset = 1'b1;
    sizes = s;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // one start pulse, then reads counted mid cycle until load_fin
  task automatic run_chunk(input int exp_reads, output int got_reads);
    int   reads;
    logic fin_seen;
    logic fin_first;
    reads = 0;
    @(posedge clk);
    #2;
    conv_load_input = 1'b1;
    @(negedge clk);
    fin_first = load_fin;
    fin_seen  = load_fin;
    if (ddr_rd_en) reads++;
    @(posedge clk);
    #2;
    conv_load_input = 1'b0;
    while (!fin_seen) begin
      @(negedge clk);
      if (ddr_rd_en) reads++;
      if (load_fin) fin_seen = 1'b1;
    end
    // let a held tile drop back to idle before the next start
    repeat (3) @(posedge clk);
    assert (reads == exp_reads) else begin
      $display("ERROR %0t: chunk read %0d words, expected %0d", $time, reads, exp_reads);
      tb_errors++;
    end
    if (exp_reads == 0) begin
      assert (fin_first) else begin
        $display("%0t: load_fin did not come in the cycle of the start pulse", $time);
        tb_errors++;
      end
    end
    got_reads = reads;
  endtask

  // every channel chunk of every tile, y outer, x inner
  task automatic run_layer(input string name, input conv_load_pkg::tile_sizes_t s);
    int errs_before;
    int n_chunks;
    int n_reads;
    int got;
    errs_before = total_errors();
    n_chunks    = 0;
    n_reads     = 0;
    for (int ty = 0; ty < tiles_y(cfg); ty++) begin
      for (int tx = 0; tx < tiles_x(cfg); tx++) begin
        for (int fc = 0; fc < chunks_per_tile(cfg); fc++) begin
          run_chunk(chunk_reads(s, cfg, tx, ty, fc), got);
          n_chunks++;
          n_reads += got;
        end
      end
    end
    tests_run++;
    $display("test %s: %0d chunks, %0d reads, %0d errors", name, n_chunks, n_reads,
             total_errors() - errs_before);
  endtask

  // run length bound from the word count of both layers
  initial begin : watchdog
    longint limit_ns;
    limit_ns = (longint'(layer_reads(make_sizes(5), make_cfg()) +
                         layer_reads(make_sizes(0), make_cfg())) * 8 +
                2 * tiles_x(make_cfg()) * tiles_y(make_cfg()) * chunks_per_tile(make_cfg()) * 12 +
                64) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired after %0d ns, load_fin never arrived", limit_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    conv_load_input = 1'b0;
    ddr_en          = 1'b0;
    lfsr_state      = 32'hf779;
    tb_errors       = 0;
    tests_run       = 0;
    cfg             = make_cfg();
    apply_reset(make_sizes(5));

    // no start yet, outputs must stay quiet
    idle_errs = total_errors();
    repeat (6) @(posedge clk);
    tests_run++;
    $display("test idle_after_reset: 6 cycles, %0d errors", total_errors() - idle_errs);

    run_layer("full_tiles", make_sizes(5));

    // last tile row has no rows, its tiles are empty
    @(posedge clk);
    #2;
    apply_reset(make_sizes(0));
    run_layer("empty_last_row", make_sizes(0));

    $display("tests run %0d, errors %0d", tests_run, total_errors());
    if (total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
